/* tb.f */
src/esp_link_pkg.sv
src/spi_rx.sv
src/cmd_decode.sv
src/cmd_execute.sv
src/reply_tx.sv
src/esp_link_top.sv
dv/tb_esp_link.sv

/* dv/tb_esp_link.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_esp_link;

  localparam int half_sck = 12;  // clk cycles per sck half period
  // about 510 bytes at 192 clk each plus ~130 frame gaps, roughly 2x margin
  localparam int cycle_limit = 200000;

  logic clk;
  logic rst_n;
  logic sck;
  logic cs_n;
  logic mosi;
  logic miso;
  esp_link_pkg::rgb_t screen_rgb;

  esp_link_pkg::byte_t tx_buf[4];     // bytes of the next frame
  esp_link_pkg::byte_t rx_buf[4];     // miso bytes seen by the master
  esp_link_pkg::byte_t ref_mem[1024]; // model ram
  esp_link_pkg::rgb_t  ref_rgb;
  logic [15:0] written_q[$];          // poked addresses, as sent
  string       name_q[$];             // pending comparisons
  logic [31:0] exp_q[$];
  logic [31:0] act_q[$];
  int          seed = 91;
  int unsigned cycle_cnt = 0;

  esp_link_top uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .sck        (sck),
    .cs_n       (cs_n),
    .mosi       (mosi),
    .miso       (miso),
    .screen_rgb (screen_rgb)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns
  end

  // run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == cycle_limit) begin
      $display("timeout after %0d cycles, the SPI traffic never finished", cycle_cnt);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
    end
  end

  // expected reply of a command, updates the model state
  function automatic esp_link_pkg::byte_t ref_model(input esp_link_pkg::cmd_t cmd,
                                                    input esp_link_pkg::byte_t p0, p1, p2);
    logic [9:0] a;
    a = {p1[1:0], p0};  // only 10 address bits reach the ram
    ref_model = 8'h00;
    case (cmd)
      esp_link_pkg::cmd_get_cookie:       ref_model = 8'haf;
      esp_link_pkg::cmd_bram_poke:        ref_mem[a] = p2;
      esp_link_pkg::cmd_bram_peek:        ref_model = ref_mem[a];
      esp_link_pkg::cmd_get_version:      ref_model = {3'd0, 5'd3};  // major 0, minor 3
      esp_link_pkg::cmd_set_screen_color: ref_rgb = {p0, p1, p2};
      default: ;  // unknown codes change nothing
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // comparisons drained once per cycle
  initial begin : compare
    string       name;
    logic [31:0] e;
    logic [31:0] a;
    forever begin
      @(negedge clk);
      while (act_q.size() > 0) begin
        name = name_q.pop_front();
        e    = exp_q.pop_front();
        a    = act_q.pop_front();
        check_value(name, e, a);
      end
    end
  end

  task automatic queue_check(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);  // last, the compare side keys on it
  endtask

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
  endtask

  // mode 0 byte, msb first, miso taken at each rising sck
  task automatic spi_byte(input esp_link_pkg::byte_t tx, output esp_link_pkg::byte_t rx);
    for (int i = 7; i >= 0; i--) begin
      mosi <= tx[i];  // changes while sck is low
      wait_clks(half_sck);
      sck <= 1'b1;
      @(negedge clk);
      rx[i] = miso;
      wait_clks(half_sck);
      sck <= 1'b0;
    end
  endtask

  task automatic spi_frame(input int n_bytes);
    esp_link_pkg::byte_t r;
    cs_n <= 1'b0;
    wait_clks(half_sck);
    for (int k = 0; k < n_bytes; k++) begin
      spi_byte(tx_buf[k], r);
      rx_buf[k] = r;
    end
    wait_clks(half_sck);
    cs_n <= 1'b1;
    wait_clks(2 * half_sck);  // gap between frames
  endtask

  // whole command in one frame, reply (if any) in the last byte slot
  task automatic send_cmd(input esp_link_pkg::cmd_t cmd, input esp_link_pkg::byte_t p0, p1, p2,
                          input int n_bytes, input bit has_reply, input string name);
    esp_link_pkg::byte_t exp;
    tx_buf[0] = cmd;
    tx_buf[1] = p0;
    tx_buf[2] = p1;
    tx_buf[3] = p2;
    spi_frame(n_bytes);
    exp = ref_model(cmd, p0, p1, p2);
    if (has_reply) begin
      queue_check(name, exp, rx_buf[n_bytes-1]);
    end
  endtask

  task automatic read_rgb(output esp_link_pkg::rgb_t v);
    @(negedge clk);
    v = screen_rgb;
    @(posedge clk);  // back on the drive edge
  endtask

  initial begin : main
    logic [15:0]         a;
    esp_link_pkg::byte_t d;
    esp_link_pkg::rgb_t  rgb;
    int                  idx;
    rst_n   = 1'b0;
    sck     = 1'b0;
    cs_n    = 1'b1;
    mosi    = 1'b0;
    ref_rgb = 24'hffffff;  // white out of reset
    wait_clks(8);
    rst_n <= 1'b1;
    wait_clks(4);
    read_rgb(rgb);
    queue_check("rgb_after_reset", ref_rgb, rgb);

    send_cmd(esp_link_pkg::cmd_get_cookie, 8'h00, 8'h00, 8'h00, 2, 1'b1, "get_cookie");
    send_cmd(esp_link_pkg::cmd_get_version, 8'h00, 8'h00, 8'h00, 2, 1'b1, "get_version");

    // random pokes, each followed by peeks of earlier addresses
    for (int i = 0; i < 40; i++) begin
      a = $random(seed);  // full 16 bits, upper ones must be dropped
      d = $random(seed);
      send_cmd(esp_link_pkg::cmd_bram_poke, a[7:0], a[15:8], d, 4, 1'b0, "bram_poke");
      written_q.push_back(a);
      repeat (2) begin
        idx = $unsigned($random(seed)) % written_q.size();
        a   = written_q[idx];
        send_cmd(esp_link_pkg::cmd_bram_peek, a[7:0], a[15:8], 8'h00, 4, 1'b1, "bram_peek");
      end
    end

    // wrap, A + 1024 lands on A
    a        = $random(seed);
    a[15:10] = 6'd0;
    d        = $random(seed);
    send_cmd(esp_link_pkg::cmd_bram_poke, a[7:0], a[15:8] + 8'd4, d, 4, 1'b0, "wrap_poke");
    send_cmd(esp_link_pkg::cmd_bram_peek, a[7:0], a[15:8], 8'h00, 4, 1'b1, "wrap_peek");
    written_q.push_back(a);

    send_cmd(esp_link_pkg::cmd_set_screen_color, 8'h12, 8'h9c, 8'he5, 4, 1'b0, "color");
    read_rgb(rgb);  // cs already high again
    queue_check("screen_rgb", ref_rgb, rgb);

    // unknown code leaves the decoder idle, next byte is a fresh command
    tx_buf[0] = 8'h5a;
    tx_buf[1] = esp_link_pkg::cmd_get_cookie;
    tx_buf[2] = 8'h00;  // reply slot
    spi_frame(3);
    d = ref_model(esp_link_pkg::cmd_get_cookie, 8'h00, 8'h00, 8'h00);
    queue_check("unknown_code", d, rx_buf[2]);

    // poke cut off after one parameter
    a         = written_q[0];
    tx_buf[0] = esp_link_pkg::cmd_bram_poke;
    tx_buf[1] = a[7:0];
    spi_frame(2);  // no model update, nothing may be written
    send_cmd(esp_link_pkg::cmd_bram_peek, a[7:0], a[15:8], 8'h00, 4, 1'b1, "peek_after_abort");
    send_cmd(esp_link_pkg::cmd_get_cookie, 8'h00, 8'h00, 8'h00, 2, 1'b1, "cookie_after_abort");

    wait_clks(4);  // let the compare side drain
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* src/esp_link_top.sv */
`timescale 1ns/1ps
`default_nettype none

module esp_link_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               sck,
  input  logic               cs_n,
  input  logic               mosi,
  output logic               miso,
  output esp_link_pkg::rgb_t screen_rgb
);

  esp_link_pkg::byte_t       rx_byte;
  esp_link_pkg::byte_t       reply_byte;
  esp_link_pkg::cmd_action_t action;
  logic rx_valid;
  logic cs_start;
  logic cs_active;
  logic sck_fall;
  logic tx_arm;
  logic tx_busy;

  // spi slave front end
  spi_rx u_spi_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .sck       (sck),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid),
    .cs_start  (cs_start),
    .cs_active (cs_active),
    .sck_fall  (sck_fall)
  );

  // command and parameter collection
  cmd_decode u_cmd_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .cs_start (cs_start),
    .tx_busy  (tx_busy),
    .action   (action),
    .tx_arm   (tx_arm)
  );

  cmd_execute u_cmd_execute (
    .clk        (clk),
    .rst_n      (rst_n),
    .action     (action),
    .reply_byte (reply_byte),
    .screen_rgb (screen_rgb)
  );

  // reply byte back on miso
  reply_tx u_reply_tx (
    .clk        (clk),
    .rst_n      (rst_n),
    .tx_arm     (tx_arm),
    .sck_fall   (sck_fall),
    .cs_active  (cs_active),
    .reply_byte (reply_byte),
    .miso       (miso),
    .tx_busy    (tx_busy)
  );

endmodule

`default_nettype wire

/* src/reply_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module reply_tx (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                tx_arm,
  input  logic                sck_fall,
  input  logic                cs_active,
  input  esp_link_pkg::byte_t reply_byte,
  output logic                miso,
  output logic                tx_busy
);

  logic [3:0] bit_cnt;    // bits still to shift out
  logic       load_pend;  // waiting for the end of the request byte
  esp_link_pkg::byte_t shift_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt   <= '0;
      load_pend <= 1'b0;
      shift_q   <= '0;
    end else if (!cs_active) begin
      bit_cnt   <= '0;   // deselect ends any reply
      load_pend <= 1'b0;
      shift_q   <= '0;
    end else if (tx_arm) begin
      bit_cnt   <= 4'd8;
      load_pend <= 1'b1;
    end else if (sck_fall) begin
      if (load_pend) begin
        // 8th fall of the request, msb goes out before the next byte
        shift_q   <= reply_byte;
        load_pend <= 1'b0;
      end else if (bit_cnt != 4'd0) begin
        shift_q <= {shift_q[6:0], 1'b0};
        bit_cnt <= bit_cnt - 4'd1;  // reaches 0 on the 8th fall of the reply
      end
    end
  end

  assign tx_busy = load_pend || (bit_cnt != 4'd0);
  assign miso    = cs_active & shift_q[7];  // plain 0 when not selected

endmodule

`default_nettype wire

/* src/cmd_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_execute (
  input  logic                      clk,
  input  logic                      rst_n,
  input  esp_link_pkg::cmd_action_t action,
  output esp_link_pkg::byte_t       reply_byte,
  output esp_link_pkg::rgb_t        screen_rgb
);

  esp_link_pkg::byte_t     mem [esp_link_pkg::mem_depth];
  esp_link_pkg::mem_addr_t addr;
  esp_link_pkg::byte_t     rd_q;     // registered ram read
  logic do_poke;
  logic do_peek;
  logic do_cookie;
  logic do_version;
  logic do_color;
  logic peek_q;                      // read data lands next cycle

  // command strobes
  assign do_poke    = action.go && (action.cmd == esp_link_pkg::cmd_bram_poke);
  assign do_peek    = action.go && (action.cmd == esp_link_pkg::cmd_bram_peek);
  assign do_cookie  = action.go && (action.cmd == esp_link_pkg::cmd_get_cookie);
  assign do_version = action.go && (action.cmd == esp_link_pkg::cmd_get_version);
  assign do_color   = action.go && (action.cmd == esp_link_pkg::cmd_set_screen_color);

  // addr hi:lo, upper bits dropped so the 1k space wraps
  assign addr = esp_link_pkg::mem_addr_t'({action.p1, action.p0});

  // single port ram, write on poke, read on peek
  always_ff @(posedge clk) begin
    if (do_poke) begin
      mem[addr] <= action.p2;
    end
    if (do_peek) begin
      rd_q <= mem[addr];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      peek_q     <= 1'b0;
      screen_rgb <= esp_link_pkg::rgb_reset;
    end else begin
      peek_q <= do_peek;
      if (do_color) begin
        screen_rgb <= {action.p0, action.p1, action.p2};  // r, g, b
      end
    end
  end

  // reply select, cookie and version at go+1, peek data at go+2
  always_ff @(posedge clk) begin
    if (do_cookie) begin
      reply_byte <= esp_link_pkg::cookie;
    end else if (do_version) begin
      reply_byte <= {esp_link_pkg::version_major, esp_link_pkg::version_minor};
    end else if (peek_q) begin
      reply_byte <= rd_q;
    end
  end

endmodule

`default_nettype wire

/* src/cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_decode (
  input  logic                      clk,
  input  logic                      rst_n,
  input  esp_link_pkg::byte_t       rx_byte,
  input  logic                      rx_valid,
  input  logic                      cs_start,
  input  logic                      tx_busy,
  output esp_link_pkg::cmd_action_t action,
  output logic                      tx_arm
);

  esp_link_pkg::decode_state_e state;
  logic [1:0] idx;       // next parameter slot
  logic [1:0] n_params;  // parameter count of the latched command
  logic       go_q;
  logic       take;      // byte accepted this cycle
  esp_link_pkg::cmd_t  cmd_q;
  esp_link_pkg::byte_t p0_q;
  esp_link_pkg::byte_t p1_q;
  esp_link_pkg::byte_t p2_q;

  // bytes clocked in during a reply slot are dummies
  assign take = rx_valid && !tx_busy && !cs_start;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= esp_link_pkg::idle;
      idx      <= '0;
      n_params <= '0;
      go_q     <= 1'b0;
      tx_arm   <= 1'b0;
    end else begin
      go_q   <= 1'b0;  // strobes
      tx_arm <= 1'b0;
      if (cs_start) begin
        state <= esp_link_pkg::idle;  // new frame drops a partial command
      end else if (take) begin
        case (state)
          esp_link_pkg::idle: begin
            idx <= '0;
            case (rx_byte)
              esp_link_pkg::cmd_get_cookie,
              esp_link_pkg::cmd_get_version: begin
                go_q   <= 1'b1;  // no params, fire at once
                tx_arm <= 1'b1;  // reply in the next byte slot
              end
              esp_link_pkg::cmd_bram_poke,
              esp_link_pkg::cmd_set_screen_color: begin
                n_params <= 2'd3;
                state    <= esp_link_pkg::read_params;
              end
              esp_link_pkg::cmd_bram_peek: begin
                n_params <= 2'd2;
                state    <= esp_link_pkg::read_params;
              end
              default: state <= esp_link_pkg::idle;  // unknown code ignored
            endcase
          end
          esp_link_pkg::read_params: begin
            if (idx == n_params - 2'd1) begin
              // last parameter arrives with this byte
              go_q   <= 1'b1;
              tx_arm <= (cmd_q == esp_link_pkg::cmd_bram_peek);
              state  <= esp_link_pkg::idle;
            end else begin
              idx <= idx + 2'd1;
            end
          end
          default: state <= esp_link_pkg::idle;
        endcase
      end
    end
  end

  // command and parameter bytes, held stable until the next frame
  always_ff @(posedge clk) begin
    if (take) begin
      if (state == esp_link_pkg::idle) begin
        cmd_q <= rx_byte;
      end else begin
        case (idx)
          2'd0:    p0_q <= rx_byte;
          2'd1:    p1_q <= rx_byte;
          default: p2_q <= rx_byte;
        endcase
      end
    end
  end

  assign action = '{go: go_q, cmd: cmd_q, p0: p0_q, p1: p1_q, p2: p2_q};

endmodule

`default_nettype wire

/* src/spi_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_rx (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                sck,
  input  logic                cs_n,
  input  logic                mosi,
  output esp_link_pkg::byte_t rx_byte,
  output logic                rx_valid,
  output logic                cs_start,
  output logic                cs_active,
  output logic                sck_fall
);

  logic [2:0] sck_q;    // two sync stages plus edge stage
  logic [2:0] cs_q;     // same for chip select
  logic [1:0] mosi_q;   // lines up with sck_q[1]
  logic [2:0] bit_cnt;  // bit position inside the byte
  logic       sck_rise;
  esp_link_pkg::byte_t shift_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sck_q  <= '0;
      cs_q   <= '1;   // deselected
      mosi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      cs_q   <= {cs_q[1:0], cs_n};
      mosi_q <= {mosi_q[0], mosi};
    end
  end

  // mode 0, sample on rising sck, master changes data on falling sck
  assign sck_rise  = (sck_q[2:1] == 2'b01);
  assign sck_fall  = (sck_q[2:1] == 2'b10);
  assign cs_active = ~cs_q[1];
  assign cs_start  = (cs_q[2:1] == 2'b10);  // cs_n just went low

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= cs_active && sck_rise && (bit_cnt == 3'd7);  // 8th bit in
      if (!cs_active) begin
        bit_cnt <= '0;  // realign on every frame
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;  // wraps after 8 bits
      end
    end
  end

  // msb first
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      shift_q <= {shift_q[6:0], mosi_q[1]};
    end
  end

  assign rx_byte = shift_q;  // complete when rx_valid is high

endmodule

`default_nettype wire

/* src/esp_link_pkg.sv */
`default_nettype none

package esp_link_pkg;

  // widths with a meaning on the link
  typedef logic [7:0] byte_t;   // one spi or data byte
  typedef logic [7:0] cmd_t;    // command code, first byte of a frame

  // command codes sent by the microcontroller
  localparam cmd_t cmd_get_cookie       = 8'd0;
  localparam cmd_t cmd_bram_poke        = 8'd1;   // addr lo, addr hi, data
  localparam cmd_t cmd_bram_peek        = 8'd2;   // addr lo, addr hi
  localparam cmd_t cmd_get_version      = 8'd15;
  localparam cmd_t cmd_set_screen_color = 8'd17;  // red, green, blue

  // small inferred ram, upper address bits dropped so addresses wrap
  localparam int mem_addr_w = 10;
  localparam int mem_depth  = 1 << mem_addr_w;
  typedef logic [mem_addr_w-1:0] mem_addr_t;

  typedef logic [23:0] rgb_t;   // red in the top byte

  // fixed reply values
  localparam byte_t      cookie        = 8'haf;
  localparam logic [2:0] version_major = 3'd0;
  localparam logic [4:0] version_minor = 5'd3;
  localparam rgb_t       rgb_reset     = 24'hffffff;  // white screen out of reset

  // decoder fsm
  typedef enum logic [1:0] {
    idle,         // waiting for a command byte
    read_params   // collecting parameter bytes
  } decode_state_e;

  // finished command handed from decode to execute
  typedef struct packed {
    logic  go;    // one cycle strobe
    cmd_t  cmd;
    byte_t p0;
    byte_t p1;
    byte_t p2;
  } cmd_action_t;

endpackage

`default_nettype wire
